// File: rv_pipe.f
+incdir+include
logic/rv_pipe_pkg.sv
logic/rv_pipe_alu.sv
logic/rv_pipe_regfile.sv
logic/rv_pipe_decode.sv
logic/rv_pipe_imem.sv
logic/rv_pipe_core.sv
logic/rv_pipe_top.sv
testbench/rv_pipe_tb.sv

// File: Makefile
# Verilator build and run of the rv_pipe testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rv_pipe_tb
FILELIST  ?= rv_pipe.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: include/rv_pipe_iss.svh
// Reference instruction-set model, random program generator and expected writeback queues
`ifndef RV_PIPE_ISS_SVH
`define RV_PIPE_ISS_SVH

// Program shape
localparam int PROG_LEN     = 48;
localparam int PROG_BODY    = 36;
localparam int SEED_REGS    = 7;
localparam int MAX_BRANCHES = 8;

instr_word_u prog [PROG_LEN];
logic [31:0] model_regs [32];

// Expected writes in program order
logic [4:0]  exp_rd_q [$];
logic [31:0] exp_data_q [$];

// ----------------------------------------
// Program generator
// ----------------------------------------
task automatic gen_program();
    instr_word_u w;
    int          k;
    int          kind;
    int          n_branch;
    logic [12:0] offset;
    n_branch = 0;
    for (k = 0; k < PROG_LEN; k++) begin
        w = NOP_WORD;
        if (k < SEED_REGS) begin
            // Prologue loads x1..x7 from x0
            w.i_view.opcode = OPC_OP_IMM;
            w.i_view.funct3 = 3'b000;
            w.i_view.rs1    = 5'd0;
            w.i_view.rd     = 5'(k + 1);
            w.i_view.imm    = 12'($urandom);
        end else if (k < PROG_BODY) begin
            kind = $urandom_range(0, 9);
            if (kind >= 8 && n_branch < MAX_BRANCHES) begin
                // Forward only, two to four words ahead
                n_branch++;
                offset            = 13'(4 * $urandom_range(2, 4));
                w.b_view.opcode   = OPC_BRANCH;
                w.b_view.funct3   = 3'($urandom_range(0, 1));
                w.b_view.rs1      = 5'($urandom_range(0, 7));
                w.b_view.rs2      = 5'($urandom_range(0, 7));
                w.b_view.imm_12   = offset[12];
                w.b_view.imm_11   = offset[11];
                w.b_view.imm_10_5 = offset[10:5];
                w.b_view.imm_4_1  = offset[4:1];
            end else if (kind < 4) begin
                // ADDI, full 12-bit range so negatives show up
                w.i_view.opcode = OPC_OP_IMM;
                w.i_view.funct3 = 3'b000;
                w.i_view.rs1    = 5'($urandom_range(0, 7));
                w.i_view.rd     = 5'($urandom_range(0, 7));
                w.i_view.imm    = 12'($urandom);
            end else begin
                w.r_view.opcode = OPC_OP;
                w.r_view.funct3 = 3'($urandom_range(0, 7));
                w.r_view.funct7 = 7'b0000000;
                // SUB and SRA variants
                if ((w.r_view.funct3 == 3'd0 || w.r_view.funct3 == 3'd5) &&
                    $urandom_range(0, 1) == 1) begin
                    w.r_view.funct7 = 7'b0100000;
                end
                w.r_view.rs1 = 5'($urandom_range(0, 7));
                w.r_view.rs2 = 5'($urandom_range(0, 7));
                w.r_view.rd  = 5'($urandom_range(0, 7));
            end
        end
        prog[k] = w;
    end
endtask

// ----------------------------------------
// Sequential reference execution
// ----------------------------------------
function automatic logic [31:0] r_type_model(input logic [6:0] funct7, input logic [2:0] funct3,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh   = b[4:0];
    // Upper bits vacated by a right shift of a negative value
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
    case (funct3)
        3'd0:    return funct7[5] ? a - b : a + b;
        3'd1:    return a << sh;
        // Signs differ means the negative one is smaller
        3'd2:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return funct7[5] ? ((a >> sh) | fill) : (a >> sh);
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic run_model();
    instr_word_u w;
    int          idx;
    int          next;
    int          r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] boff;
    logic        wr;
    logic        taken;
    exp_rd_q.delete();
    exp_data_q.delete();
    for (r = 0; r < 32; r++) begin
        model_regs[r] = 32'd0;
    end
    idx = 0;
    while (idx < PROG_LEN) begin
        w     = prog[idx];
        a     = model_regs[w.r_view.rs1];
        b     = model_regs[w.r_view.rs2];
        wr    = 1'b0;
        res   = 32'd0;
        next  = idx + 1;
        case (w.r_view.opcode)
            OPC_OP: begin
                wr  = 1'b1;
                res = r_type_model(w.r_view.funct7, w.r_view.funct3, a, b);
            end
            OPC_OP_IMM: begin
                wr  = w.i_view.funct3 == 3'b000;
                res = a + {{20{w.i_view.imm[11]}}, w.i_view.imm};
            end
            OPC_BRANCH: begin
                boff  = {{19{w.b_view.imm_12}}, w.b_view.imm_12, w.b_view.imm_11,
                         w.b_view.imm_10_5, w.b_view.imm_4_1, 1'b0};
                taken = (w.b_view.funct3 == 3'b000) ? (a == b) : (a != b);
                if (taken) begin
                    next = idx + int'($signed(boff)) / 4;
                end
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        // x0 writes are dropped and never reported
        if (wr && w.r_view.rd != 5'd0) begin
            model_regs[w.r_view.rd] = res;
            exp_rd_q.push_back(w.r_view.rd);
            exp_data_q.push_back(res);
        end
        idx = next;
    end
endtask

`endif

// File: testbench/rv_pipe_tb.sv
// Testbench for rv_pipe_top: clock, reset and load, writeback checks, watchdog and result
`default_nettype none

module rv_pipe_tb
    import rv_pipe_pkg::*;
();

    localparam int IMEM_DEPTH   = 64;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RUNS     = 20;
    // Last real writeback lands by cycle 47, a wrapped fetch cannot reach WB before 60
    localparam int RUN_CYCLES   = 52;

    logic        clk;
    logic        exmem_reset;
    logic        imem_load_en;
    logic [31:0] imem_load_addr;
    logic [31:0] imem_load_data;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    int wb_count;

    `include "rv_pipe_iss.svh"

    localparam int WATCHDOG_TIME = NUM_RUNS * (RESET_CYCLES + PROG_LEN * 4 + 16) * CLK_PERIOD;

    rv_pipe_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) rv_pipe_top_inst (
        .clk            (clk),
        .exmem_reset    (exmem_reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ----------------------------------------
    // Failure handling and checks
    // ----------------------------------------
    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Called mid-cycle, outputs settled since the rising edge
    task automatic sample_writeback(input bit in_reset);
        if (!in_reset && wb_en === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("Unexpected writeback to x%0d at time %0t", wb_rd, $time);
                abort_run();
            end else begin
                check_value("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd_q.pop_front()});
                check_value("wb_data", wb_data, exp_data_q.pop_front());
                wb_count++;
            end
        end else begin
            // Low during reset and between writes, never unknown
            check_value("wb_en", {31'd0, wb_en}, 32'd0);
        end
    endtask

    // ----------------------------------------
    // Reset, load and run
    // ----------------------------------------
    task automatic load_and_reset();
        int c;
        for (c = 0; c < RESET_CYCLES || c < PROG_LEN; c++) begin
            @(posedge clk);
            #1;
            exmem_reset  = 1'b1;
            imem_load_en = c < PROG_LEN;
            if (c < PROG_LEN) begin
                imem_load_addr = c;
                imem_load_data = prog[c];
            end
            @(negedge clk);
            // First cycle still shows the previous run
            if (c > 0) begin
                sample_writeback(1'b1);
            end
        end
    endtask

    task automatic run_program();
        int c;
        for (c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            #1;
            if (c == 0) begin
                exmem_reset    = 1'b0;
                imem_load_en   = 1'b0;
                imem_load_addr = 32'd0;
                imem_load_data = 32'd0;
            end
            @(negedge clk);
            sample_writeback(1'b0);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int run;
        wb_count       = 0;
        exmem_reset    = 1'b0;
        imem_load_en   = 1'b0;
        imem_load_addr = 32'd0;
        imem_load_data = 32'd0;
        void'($urandom(32'h4316));
        for (run = 0; run < NUM_RUNS; run++) begin
            gen_program();
            run_model();
            load_and_reset();
            run_program();
            // Every model write must have shown up
            if (exp_rd_q.size() != 0) begin
                $display("Run %0d ended with %0d expected writebacks missing",
                         run, exp_rd_q.size());
                abort_run();
            end
        end
        $display("Checked %0d writebacks over %0d programs", wb_count, NUM_RUNS);
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog timeout, run did not finish within %0d time units", WATCHDOG_TIME);
        abort_run();
    end

endmodule

`default_nettype wire

// File: logic/rv_pipe_top.sv
// Top level with the pipeline core and its program memory
`default_nettype none

module rv_pipe_top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        exmem_reset,
    input  logic        imem_load_en,
    input  logic [31:0] imem_load_addr,
    input  logic [31:0] imem_load_data,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [31:0] fetch_pc;
    logic [31:0] fetch_instr;

    // Program store, loaded during reset
    rv_pipe_imem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) rv_pipe_imem_inst (
        .clk         (clk),
        .exmem_reset (exmem_reset),
        .load_en     (imem_load_en),
        .load_addr   (imem_load_addr),
        .load_data   (imem_load_data),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    rv_pipe_core rv_pipe_core_inst (
        .clk         (clk),
        .exmem_reset (exmem_reset),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: logic/rv_pipe_core.sv
// Five-stage pipeline core with forwarding, branch resolution and flush
`default_nettype none

module rv_pipe_core
    import rv_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        exmem_reset,
    input  logic [31:0] fetch_instr,
    output logic [31:0] fetch_pc,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    // IF/ID
    logic [31:0] pc;
    logic [31:0] ifid_pc;
    logic [31:0] ifid_instr;

    // ID/EX
    logic [31:0] idex_pc;
    logic [4:0]  idex_rs1;
    logic [4:0]  idex_rs2;
    logic [4:0]  idex_rd;
    logic [31:0] idex_imm;
    alu_op_e     idex_alu_op;
    logic        idex_alu_src_imm;
    logic        idex_reg_write;
    branch_op_e  idex_branch_op;
    logic [31:0] idex_rdata1;
    logic [31:0] idex_rdata2;

    // EX/MEM and MEM/WB
    logic        exmem_reg_write;
    logic [4:0]  exmem_rd;
    logic [31:0] exmem_alu_out;
    logic        memwb_reg_write;
    logic [4:0]  memwb_rd;
    logic [31:0] memwb_data;

    // Decode outputs
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic [4:0]  id_rd;
    logic [31:0] id_imm;
    alu_op_e     id_alu_op;
    logic        id_alu_src_imm;
    logic        id_reg_write;
    branch_op_e  id_branch_op;
    logic [31:0] id_rdata1;
    logic [31:0] id_rdata2;

    // Execute signals
    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        br_taken;
    logic [31:0] br_target;

    // ----------------------------------------
    // IF stage
    // ----------------------------------------
    assign fetch_pc = pc;

    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            pc <= 32'd0;
        end else if (br_taken) begin
            pc <= br_target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Taken branch turns the fetched word into a bubble
    always_ff @(posedge clk) begin
        if (exmem_reset || br_taken) begin
            ifid_instr <= NOP_WORD;
        end else begin
            ifid_instr <= fetch_instr;
        end
        ifid_pc <= pc;
    end

    // ----------------------------------------
    // ID stage
    // ----------------------------------------
    rv_pipe_decode rv_pipe_decode_inst (
        .instr       (ifid_instr),
        .rs1         (id_rs1),
        .rs2         (id_rs2),
        .rd          (id_rd),
        .imm         (id_imm),
        .alu_op      (id_alu_op),
        .alu_src_imm (id_alu_src_imm),
        .reg_write   (id_reg_write),
        .branch_op   (id_branch_op)
    );

    // Written from WB, read here
    rv_pipe_regfile rv_pipe_regfile_inst (
        .clk    (clk),
        .rs1    (id_rs1),
        .rs2    (id_rs2),
        .we     (memwb_reg_write),
        .rd     (memwb_rd),
        .wdata  (memwb_data),
        .rdata1 (id_rdata1),
        .rdata2 (id_rdata2)
    );

    // Bubble on reset or flush
    always_ff @(posedge clk) begin
        if (exmem_reset || br_taken) begin
            idex_reg_write <= 1'b0;
            idex_branch_op <= BR_NONE;
        end else begin
            idex_reg_write <= id_reg_write;
            idex_branch_op <= id_branch_op;
        end
        idex_pc          <= ifid_pc;
        idex_rs1         <= id_rs1;
        idex_rs2         <= id_rs2;
        idex_rd          <= id_rd;
        idex_imm         <= id_imm;
        idex_alu_op      <= id_alu_op;
        idex_alu_src_imm <= id_alu_src_imm;
        idex_rdata1      <= id_rdata1;
        idex_rdata2      <= id_rdata2;
    end

    // ----------------------------------------
    // EX stage
    // ----------------------------------------
    // Forwarding: EX/MEM first, then MEM/WB, never from x0
    always_comb begin
        if (exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs1) begin
            fwd_a = exmem_alu_out;
        end else if (memwb_reg_write && memwb_rd != 5'd0 && memwb_rd == idex_rs1) begin
            fwd_a = memwb_data;
        end else begin
            fwd_a = idex_rdata1;
        end
    end

    always_comb begin
        if (exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs2) begin
            fwd_b = exmem_alu_out;
        end else if (memwb_reg_write && memwb_rd != 5'd0 && memwb_rd == idex_rs2) begin
            fwd_b = memwb_data;
        end else begin
            fwd_b = idex_rdata2;
        end
    end

    assign alu_b = idex_alu_src_imm ? idex_imm : fwd_b;

    rv_pipe_alu rv_pipe_alu_inst (
        .op     (idex_alu_op),
        .a      (fwd_a),
        .b      (alu_b),
        .result (alu_out)
    );

    // Branch compare on forwarded operands
    assign br_taken  = (idex_branch_op == BR_BEQ && fwd_a == fwd_b) ||
                       (idex_branch_op == BR_BNE && fwd_a != fwd_b);
    assign br_target = idex_pc + idex_imm;

    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            exmem_reg_write <= 1'b0;
        end else begin
            exmem_reg_write <= idex_reg_write;
        end
        exmem_rd      <= idex_rd;
        exmem_alu_out <= alu_out;
    end

    // ----------------------------------------
    // MEM stage
    // ----------------------------------------
    // No data memory, result just moves on
    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            memwb_reg_write <= 1'b0;
        end else begin
            memwb_reg_write <= exmem_reg_write;
        end
        memwb_rd   <= exmem_rd;
        memwb_data <= exmem_alu_out;
    end

    // ----------------------------------------
    // WB stage
    // ----------------------------------------
    // Strobe held for the cycle spent in WB
    assign wb_en   = memwb_reg_write;
    assign wb_rd   = memwb_rd;
    assign wb_data = memwb_data;

endmodule

`default_nettype wire

// File: logic/rv_pipe_imem.sv
// Program memory with a load port and a combinational fetch port
`default_nettype none

module rv_pipe_imem
    import rv_pipe_pkg::*;
#(
    parameter int IMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        exmem_reset,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] fetch_pc,
    output logic [31:0] fetch_instr
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [31:0]   mem [IMEM_DEPTH];
    logic          reset_q;
    logic [AW-1:0] load_idx;
    logic [AW-1:0] fetch_idx;

    // Word indices wrap modulo depth
    assign load_idx  = AW'(load_addr % IMEM_DEPTH);
    assign fetch_idx = AW'((fetch_pc >> 2) % IMEM_DEPTH);

    // Delayed reset to spot its first cycle
    always_ff @(posedge clk) begin
        reset_q <= exmem_reset;
    end

    // First reset cycle fills with NOPs
    // A load in that same cycle still lands, as it is assigned last
    always_ff @(posedge clk) begin
        if (exmem_reset && !reset_q) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                mem[i] <= NOP_WORD;
            end
        end
        if (load_en) begin
            mem[load_idx] <= load_data;
        end
    end

    assign fetch_instr = mem[fetch_idx];

endmodule

`default_nettype wire

// File: logic/rv_pipe_decode.sv
// Instruction decoder for R-type ALU ops, ADDI, BEQ and BNE
`default_nettype none

module rv_pipe_decode
    import rv_pipe_pkg::*;
(
    input  instr_word_u instr,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] imm,
    output alu_op_e     alu_op,
    output logic        alu_src_imm,
    output logic        reg_write,
    output branch_op_e  branch_op
);

    logic [31:0] i_imm;
    logic [31:0] b_imm;
    logic        alt;
    logic        r_legal;

    // Sign-extended immediates
    assign i_imm = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
    assign b_imm = {{19{instr.b_view.imm_12}}, instr.b_view.imm_12, instr.b_view.imm_11,
                    instr.b_view.imm_10_5, instr.b_view.imm_4_1, 1'b0};

    // funct7 0100000 marks SUB and SRA
    assign alt     = instr.r_view.funct7 == 7'b0100000;
    assign r_legal = instr.r_view.funct7 == 7'b0000000 ||
                     (alt && (instr.r_view.funct3 == 3'b000 || instr.r_view.funct3 == 3'b101));

    always_comb begin
        // Defaults decode as a no-op
        rs1         = instr.r_view.rs1;
        rs2         = instr.r_view.rs2;
        rd          = instr.r_view.rd;
        imm         = i_imm;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        branch_op   = BR_NONE;

        case (instr.r_view.opcode)
            OPC_OP: begin
                reg_write = r_legal;
                case (instr.r_view.funct3)
                    3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                alu_src_imm = 1'b1;
                reg_write   = instr.i_view.funct3 == 3'b000;
            end
            OPC_BRANCH: begin
                imm = b_imm;
                case (instr.b_view.funct3)
                    3'b000:  branch_op = BR_BEQ;
                    3'b001:  branch_op = BR_BNE;
                    default: branch_op = BR_NONE;
                endcase
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase

        // x0 is never written
        if (rd == 5'd0) begin
            reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_pipe_regfile.sv
// Integer register file, x0 tied to zero, reads see same-cycle writes
`default_nettype none

module rv_pipe_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // Only x1..x31 have storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Write-through so WB feeds ID in the same cycle
    always_comb begin
        if (rs1 == 5'd0) begin
            rdata1 = 32'd0;
        end else if (we && rd == rs1) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rdata2 = 32'd0;
        end else if (we && rd == rs2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_pipe_alu.sv
// Combinational integer ALU for the R-type operation set
`default_nettype none

module rv_pipe_alu
    import rv_pipe_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0] shamt;

    // Shift amount from the low bits only
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            // Compares yield 0 or 1
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_pipe_pkg.sv
// Shared ALU and branch codes, opcode constants and the instruction word union
`default_nettype none

package rv_pipe_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Branch kind carried down to EX
    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } branch_op_e;

    // Major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ADDI x0,x0,0 used as bubble and memory fill
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        // Scrambled B-type offset bits
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_view;
    } instr_word_u;

endpackage

`default_nettype wire
